/* rtl/stat_pkg.sv */
package stat_pkg;

    // byte lanes on the monitored 64-bit stream
    localparam int KEEP_WIDTH = 8;

    // statistics counter width and its size in the report
    localparam int CNT_WIDTH = 32;
    localparam int CNT_BYTES = (CNT_WIDTH + 7) / 8;

    // counter part of a report: tick, bytes, frames
    localparam int CNT_REPORT_BYTES = 3 * CNT_BYTES;

    // one sample of the monitored link
    typedef struct packed {
        logic [KEEP_WIDTH-1:0] keep;
        logic                  valid;
        logic                  ready;
        logic                  last;
    } stat_beat_t;

    // frozen counter set, tick sits in the msbs so it is sent first
    typedef struct packed {
        logic [CNT_WIDTH-1:0] tick;
        logic [CNT_WIDTH-1:0] bytes;
        logic [CNT_WIDTH-1:0] frames;
    } stat_snap_t;

    // one byte of the report stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stat_byte_t;

    typedef enum logic {
        REPORT_IDLE,
        REPORT_SEND
    } report_state_t;

endpackage

/* rtl/stat_collect.sv */
`timescale 1ns/1ps

module stat_collect (
    input  logic                clk,
    input  logic                rst,
    input  stat_pkg::stat_beat_t mon,
    input  logic                trigger_accept,
    output stat_pkg::stat_snap_t snap
);

    // running counters
    logic [stat_pkg::CNT_WIDTH-1:0] tick_cnt;
    logic [stat_pkg::CNT_WIDTH-1:0] byte_cnt;
    logic [stat_pkg::CNT_WIDTH-1:0] frame_cnt;

    // set between a frame's first beat and its last beat
    logic frame_open;

    logic                           xfer;
    logic [stat_pkg::CNT_WIDTH-1:0] lanes;
    logic [stat_pkg::CNT_WIDTH-1:0] tick_base;
    logic [stat_pkg::CNT_WIDTH-1:0] byte_base;
    logic [stat_pkg::CNT_WIDTH-1:0] frame_base;
    logic [stat_pkg::CNT_WIDTH-1:0] tick_next;
    logic [stat_pkg::CNT_WIDTH-1:0] byte_next;
    logic [stat_pkg::CNT_WIDTH-1:0] frame_next;

    // number of set keep bits, keep need not be contiguous
    function automatic logic [stat_pkg::CNT_WIDTH-1:0] count_lanes(
        input logic [stat_pkg::KEEP_WIDTH-1:0] keep
    );
        logic [stat_pkg::CNT_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < stat_pkg::KEEP_WIDTH; i++) begin
            n = n + stat_pkg::CNT_WIDTH'(keep[i]);
        end
        return n;
    endfunction

    always_comb begin
        xfer  = mon.valid && mon.ready;
        lanes = count_lanes(mon.keep);

        // a trigger restarts the window, this cycle already belongs to the new one
        tick_base  = trigger_accept ? '0 : tick_cnt;
        byte_base  = trigger_accept ? '0 : byte_cnt;
        frame_base = trigger_accept ? '0 : frame_cnt;

        // every cycle offers KEEP_WIDTH byte slots
        tick_next  = tick_base + stat_pkg::CNT_WIDTH'(stat_pkg::KEEP_WIDTH);
        byte_next  = byte_base;
        frame_next = frame_base;

        if (xfer) begin
            byte_next = byte_base + lanes;
            // first beat after a last beat opens a new frame
            if (!frame_open) begin
                frame_next = frame_base + stat_pkg::CNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt   <= '0;
            byte_cnt   <= '0;
            frame_cnt  <= '0;
            frame_open <= 1'b0;
        end else begin
            tick_cnt  <= tick_next;
            byte_cnt  <= byte_next;
            frame_cnt <= frame_next;
            if (xfer) begin
                frame_open <= !mon.last;
            end
        end
    end

    // snapshot holds the old window until the next trigger
    always_ff @(posedge clk) begin
        if (trigger_accept) begin
            snap.tick   <= tick_cnt;
            snap.bytes  <= byte_cnt;
            snap.frames <= frame_cnt;
        end
    end

endmodule

/* rtl/stat_report.sv */
`timescale 1ns/1ps

module stat_report #(
    parameter int TAG_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [TAG_WIDTH-1:0] tag,
    input  logic                 trigger,
    input  stat_pkg::stat_snap_t snap,
    output logic                 trigger_accept,
    output stat_pkg::stat_byte_t rep_byte,
    output logic                 rep_valid,
    input  logic                 rep_ready,
    output logic                 busy
);

    localparam int TAG_BYTES = (TAG_WIDTH + 7) / 8;
    localparam int TOTAL     = TAG_BYTES + stat_pkg::CNT_REPORT_BYTES;
    localparam int PTR_WIDTH = $clog2(TOTAL);

    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(TOTAL - 1);

    stat_pkg::report_state_t state;
    stat_pkg::report_state_t state_next;

    logic [PTR_WIDTH-1:0] ptr;
    logic [PTR_WIDTH-1:0] ptr_next;

    // tag zero-padded up to whole bytes
    logic [TAG_BYTES*8-1:0] tag_ext;

    // the whole report, first byte in the msbs
    logic [TOTAL*8-1:0] report_vec;

    logic is_last;

    assign tag_ext    = (TAG_BYTES * 8)'(tag);
    assign report_vec = {tag_ext, snap};
    assign is_last    = (ptr == LAST_PTR);

    // byte under the pointer, counted from the msb end
    always_comb begin
        rep_byte.data = report_vec[(TOTAL - 1 - int'(ptr)) * 8 +: 8];
        rep_byte.last = is_last;
    end

    always_comb begin
        state_next     = state;
        ptr_next       = ptr;
        trigger_accept = 1'b0;
        rep_valid      = 1'b0;

        case (state)
            stat_pkg::REPORT_IDLE: begin
                if (trigger) begin
                    // collector freezes snap on this pulse
                    trigger_accept = 1'b1;
                    ptr_next       = '0;
                    state_next     = stat_pkg::REPORT_SEND;
                end
            end
            stat_pkg::REPORT_SEND: begin
                // ready is registered in the skid, so offer only when it is up
                if (rep_ready) begin
                    rep_valid = 1'b1;
                    ptr_next  = ptr + PTR_WIDTH'(1);
                    if (is_last) begin
                        state_next = stat_pkg::REPORT_IDLE;
                    end
                end
            end
            default: begin
                state_next = stat_pkg::REPORT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stat_pkg::REPORT_IDLE;
            ptr   <= '0;
        end else begin
            state <= state_next;
            ptr   <= ptr_next;
        end
    end

    // busy while a report is being sent, triggers are dropped meanwhile
    assign busy = (state == stat_pkg::REPORT_SEND);

endmodule

/* rtl/axis_skid_reg.sv */
`timescale 1ns/1ps

module axis_skid_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  stat_pkg::stat_byte_t s_byte,
    input  logic                 s_valid,
    output logic                 s_ready,
    output stat_pkg::stat_byte_t m_byte,
    output logic                 m_valid,
    input  logic                 m_ready
);

    // output entry
    stat_pkg::stat_byte_t out_byte;
    logic                 out_valid;
    logic                 out_valid_next;

    // temporary entry, catches the byte accepted after a stall
    stat_pkg::stat_byte_t tmp_byte;
    logic                 tmp_valid;
    logic                 tmp_valid_next;

    logic s_ready_reg;
    logic s_ready_early;

    logic load_in_to_out;
    logic load_in_to_tmp;
    logic load_tmp_to_out;

    // ready next cycle if the sink takes data or both entries are empty
    assign s_ready_early = m_ready || (!tmp_valid && !out_valid);

    always_comb begin
        out_valid_next  = out_valid;
        tmp_valid_next  = tmp_valid;
        load_in_to_out  = 1'b0;
        load_in_to_tmp  = 1'b0;
        load_tmp_to_out = 1'b0;

        if (s_ready_reg) begin
            if (m_ready || !out_valid) begin
                out_valid_next = s_valid;
                load_in_to_out = 1'b1;
            end else begin
                tmp_valid_next = s_valid;
                load_in_to_tmp = 1'b1;
            end
        end else if (m_ready) begin
            // drain the temporary entry
            out_valid_next  = tmp_valid;
            tmp_valid_next  = 1'b0;
            load_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            tmp_valid   <= 1'b0;
            s_ready_reg <= 1'b0;
        end else begin
            out_valid   <= out_valid_next;
            tmp_valid   <= tmp_valid_next;
            s_ready_reg <= s_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_in_to_out) begin
            out_byte <= s_byte;
        end else if (load_tmp_to_out) begin
            out_byte <= tmp_byte;
        end
        if (load_in_to_tmp) begin
            tmp_byte <= s_byte;
        end
    end

    assign s_ready = s_ready_reg;
    assign m_byte  = out_byte;
    assign m_valid = out_valid;

endmodule

/* rtl/stat_monitor_top.sv */
`timescale 1ns/1ps

module stat_monitor_top #(
    parameter int TAG_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    // monitored link, sampled every cycle
    input  stat_pkg::stat_beat_t mon,
    // report control
    input  logic [TAG_WIDTH-1:0] tag,
    input  logic                 trigger,
    // byte-wide report stream
    output stat_pkg::stat_byte_t m_byte,
    output logic                 m_valid,
    input  logic                 m_ready,
    output logic                 busy
);

    logic                 trigger_accept;
    stat_pkg::stat_snap_t snap;

    stat_pkg::stat_byte_t rep_byte;
    logic                 rep_valid;
    logic                 rep_ready;

    stat_collect collect_i (
        .clk            (clk),
        .rst            (rst),
        .mon            (mon),
        .trigger_accept (trigger_accept),
        .snap           (snap)
    );

    stat_report #(
        .TAG_WIDTH (TAG_WIDTH)
    ) report_i (
        .clk            (clk),
        .rst            (rst),
        .tag            (tag),
        .trigger        (trigger),
        .snap           (snap),
        .trigger_accept (trigger_accept),
        .rep_byte       (rep_byte),
        .rep_valid      (rep_valid),
        .rep_ready      (rep_ready),
        .busy           (busy)
    );

    // absorbs back-pressure on the report output
    axis_skid_reg skid_i (
        .clk     (clk),
        .rst     (rst),
        .s_byte  (rep_byte),
        .s_valid (rep_valid),
        .s_ready (rep_ready),
        .m_byte  (m_byte),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

/* verif/stat_monitor_tb.sv */
`timescale 1ns/1ps

module stat_monitor_tb;

    localparam int TAG_WIDTH  = 16;
    localparam int TAG_BYTES  = (TAG_WIDTH + 7) / 8;
    localparam int REPORT_LEN = TAG_BYTES + 3 * stat_pkg::CNT_BYTES;
    localparam int NUM_TESTS  = 7;

    // one row of the stimulus table
    typedef struct packed {
        int unsigned          window;
        int unsigned          keep_cnt;
        int unsigned          frame_len;
        logic [TAG_WIDTH-1:0] tag;
        logic                 throttle;
    } test_row_t;

    logic                 clk = 1'b0;
    logic                 rst;
    stat_pkg::stat_beat_t mon = '0;
    logic [TAG_WIDTH-1:0] tag;
    logic                 trigger;
    stat_pkg::stat_byte_t m_byte;
    logic                 m_valid;
    logic                 m_ready = 1'b0;
    logic                 busy;

    test_row_t tests [NUM_TESTS];

    // stream model
    logic [31:0] rng = 32'd68;
    int          cur_keep = 0;
    int          cur_frame_len = 1;
    logic        cur_throttle = 1'b0;
    int          beat_idx = 0;
    logic        beat_valid;
    logic        beat_ready;
    logic        beat_last;

    // high with the one pulse per row that the DUT has to take
    logic        expect_accept = 1'b0;

    // counter model
    logic [31:0] model_tick;
    logic [31:0] model_bytes;
    logic [31:0] model_frames;
    logic        model_frame_open;
    logic [31:0] snap_tick = '0;
    logic [31:0] snap_bytes = '0;
    logic [31:0] snap_frames = '0;

    // report checker, each entry is {data, last}
    logic [8:0] exp_q [$];
    int         rx_total = 0;
    int         errors = 0;
    logic       reset_bad = 1'b0;

    int cycles = 0;
    int cycle_limit = 0;
    int cur_test = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int err_before;

    stat_monitor_top #(
        .TAG_WIDTH (TAG_WIDTH)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .mon     (mon),
        .tag     (tag),
        .trigger (trigger),
        .m_byte  (m_byte),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .busy    (busy)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // low n lanes set
    function automatic logic [stat_pkg::KEEP_WIDTH-1:0] lane_mask(input int n);
        logic [stat_pkg::KEEP_WIDTH-1:0] m;
        m = '0;
        for (int i = 0; i < stat_pkg::KEEP_WIDTH; i++) begin
            if (i < n) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    task automatic fill_table();
        // window, keep lanes, frame beats, tag, throttle
        tests[0] = '{20, 0, 1, 16'hA5C3, 1'b0};
        tests[1] = '{40, 8, 4, 16'h1234, 1'b0};
        tests[2] = '{35, 3, 6, 16'hBEEF, 1'b0};
        tests[3] = '{25, 5, 50, 16'h0F0F, 1'b1};
        tests[4] = '{30, 8, 2, 16'h7E81, 1'b1};
        tests[5] = '{15, 1, 3, 16'hC001, 1'b1};
        tests[6] = '{50, 7, 9, 16'h5A5A, 1'b0};
    endtask

    // msb first, last flag only on the final byte of the report
    task automatic push_field(input logic [31:0] value, input int nbytes, input logic ends);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_q.push_back({value[i*8 +: 8], ends && (i == 0)});
        end
    endtask

    task automatic check_byte();
        int         idx;
        logic [8:0] exp_b;
        idx = rx_total % REPORT_LEN;
        if (exp_q.size() == 0) begin
            $display("an extra report byte %h arrived at %0t with no report pending",
                     m_byte.data, $time);
            errors++;
        end else begin
            exp_b = exp_q.pop_front();
            if ({m_byte.data, m_byte.last} !== exp_b) begin
                $display("Error at %0t: byte %0d expected %h last %b, got %h last %b",
                         $time, idx, exp_b[8:1], exp_b[0], m_byte.data, m_byte.last);
                errors++;
            end
        end
        rx_total++;
    endtask

    // monitored link and output ready, one random draw per cycle
    always @(posedge clk) begin
        if (rst) begin
            mon     <= '0;
            m_ready <= 1'b0;
            beat_idx = 0;
        end else begin
            rng        = next_random(rng);
            beat_valid = (cur_keep != 0) && (rng[2:0] != 3'd0);
            beat_ready = (rng[5:3] > 3'd1);
            beat_last  = (beat_idx + 1 >= cur_frame_len);
            mon.keep  <= lane_mask(cur_keep);
            mon.valid <= beat_valid;
            mon.ready <= beat_ready;
            mon.last  <= beat_last;
            if (beat_valid && beat_ready) begin
                beat_idx = beat_last ? 0 : beat_idx + 1;
            end
            m_ready <= cur_throttle ? (rng[9:8] != 2'd0) : 1'b1;
        end
    end

    // values here are the ones the next rising edge samples
    always @(negedge clk) begin
        if (rst) begin
            model_tick       = '0;
            model_bytes      = '0;
            model_frames     = '0;
            model_frame_open = 1'b0;
        end else begin
            if (expect_accept) begin
                snap_tick   = model_tick;
                snap_bytes  = model_bytes;
                snap_frames = model_frames;
                push_field(32'(tag), TAG_BYTES, 1'b0);
                push_field(model_tick, stat_pkg::CNT_BYTES, 1'b0);
                push_field(model_bytes, stat_pkg::CNT_BYTES, 1'b0);
                push_field(model_frames, stat_pkg::CNT_BYTES, 1'b1);
                model_tick   = '0;
                model_bytes  = '0;
                model_frames = '0;
            end
            model_tick = model_tick + 32'(stat_pkg::KEEP_WIDTH);
            if (mon.valid && mon.ready) begin
                model_bytes = model_bytes + 32'($countones(mon.keep));
                if (!model_frame_open) begin
                    model_frames = model_frames + 32'd1;
                end
                model_frame_open = !mon.last;
            end
            if (m_valid && m_ready) begin
                check_byte();
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the report of test %0d never completed",
                     cycles, cur_test);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        fill_table();
        cycle_limit = 100;
        for (int r = 0; r < NUM_TESTS; r++) begin
            cycle_limit = cycle_limit + int'(tests[r].window) + 60;
        end

        rst     = 1'b1;
        tag     = '0;
        trigger = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (m_valid || busy) begin
            $display("Error at %0t: after reset m_valid %b busy %b, expected both low",
                     $time, m_valid, busy);
            reset_bad = 1'b1;
        end

        for (int r = 0; r < NUM_TESTS; r++) begin
            cur_test   = r;
            err_before = errors;
            @(posedge clk);
            tag           <= tests[r].tag;
            cur_keep      <= int'(tests[r].keep_cnt);
            cur_frame_len <= int'(tests[r].frame_len);
            cur_throttle  <= tests[r].throttle;
            repeat (tests[r].window) @(posedge clk);

            trigger       <= 1'b1;
            expect_accept <= 1'b1;
            @(posedge clk);
            trigger       <= 1'b0;
            expect_accept <= 1'b0;

            // busy rises the cycle after acceptance
            @(negedge clk);
            if (!busy) begin
                $display("Error at %0t: busy low after an accepted trigger, expected high",
                         $time);
                errors++;
            end

            // a second pulse while busy must be dropped
            @(posedge clk);
            trigger <= 1'b1;
            @(posedge clk);
            trigger <= 1'b0;

            while (rx_total < (r + 1) * REPORT_LEN) begin
                @(posedge clk);
            end

            if (errors == err_before) begin
                pass_cnt++;
                $display("test %0d pass: tag %h tick %0d bytes %0d frames %0d",
                         r, tests[r].tag, snap_tick, snap_bytes, snap_frames);
            end else begin
                fail_cnt++;
                $display("test %0d fail: %0d byte errors", r, errors - err_before);
            end
        end

        // stray bytes after the last report show up as extra bytes
        repeat (20) @(posedge clk);

        $display("tests passed: %0d, failed: %0d, byte errors: %0d",
                 pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0 && !reset_bad) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* stat_monitor_top.f */
rtl/stat_pkg.sv
rtl/stat_collect.sv
rtl/stat_report.sv
rtl/axis_skid_reg.sv
rtl/stat_monitor_top.sv
verif/stat_monitor_tb.sv

/* Makefile */
TB_TOP = stat_monitor_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f stat_monitor_top.f --top-module stat_monitor_top

# the run passes only if the pass line shows up in the simulation output
sim:
	verilator --binary --timing -Wno-fatal -j 0 -f stat_monitor_top.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
